/* design/kd_tree_pkg.sv */
package kd_tree_pkg;

  // Patch geometry, one coordinate is a signed 11 bit value
  localparam int dim_width     = 11;
  localparam int num_dims      = 5;
  localparam int patch_width   = dim_width * num_dims; // 55 bits, dimension 0 in the low bits

  // Node write word layout
  localparam int idx_width     = 3;  // Only the low bits of the index field are kept
  localparam int storage_width = 22; // Index field in [10:0], median in [21:11]

  // Host command opcodes
  typedef enum logic [1:0] {
    op_nop        = 2'd0,
    op_write_node = 2'd1, // Load one node from cmd_addr and cmd_wdata
    op_query      = 2'd2, // Send cmd_patch down the tree
    op_clear      = 2'd3  // Return every node to its reset contents
  } kd_op_e;

  // Load state of the tree as seen by the control block
  typedef enum logic [1:0] {
    st_empty   = 2'd0, // Nothing written since reset or clear
    st_loading = 2'd1, // Some nodes written
    st_ready   = 2'd2  // Every node written, queries are admitted
  } kd_state_e;

endpackage

/* design/internal_node.sv */
`timescale 1ns/10ps

module internal_node (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  wen,      // Write strobe for this node only
  input  logic                                  clear,    // Tree wide clear pulse
  input  logic [kd_tree_pkg::storage_width-1:0] wdata,
  input  logic [kd_tree_pkg::patch_width-1:0]   patch_in,
  output logic                                  go_right
);

  logic        [kd_tree_pkg::idx_width-1:0] idx;    // Split dimension
  logic signed [kd_tree_pkg::dim_width-1:0] median; // Split value, two's complement
  logic signed [kd_tree_pkg::dim_width-1:0] coord;  // Coordinate picked out of the patch

  // Index 7 after reset marks an unloaded node, it selects 0 so the node stays harmless
  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      idx    <= '1;
      median <= '0;
    end else if (wen) begin
      idx    <= wdata[kd_tree_pkg::idx_width-1:0]; // Low bits of the index field
      median <= wdata[kd_tree_pkg::storage_width-1:kd_tree_pkg::dim_width];
    end
  end

  // Dimension d sits in bits d*11 +: 11 of the patch, so dimension 4 is bits 54..44
  always_comb begin
    if (idx < kd_tree_pkg::num_dims) begin
      coord = patch_in[idx*kd_tree_pkg::dim_width +: kd_tree_pkg::dim_width];
    end else begin
      coord = '0; // Indices 5 to 7 name no dimension
    end
  end

  // Both operands are signed, so negative coordinates order correctly
  // Equal values go right
  assign go_right = (coord >= median);

endmodule

/* design/kd_tree_level.sv */
`timescale 1ns/10ps

module kd_tree_level #(
  parameter int DEPTH = 3,
  parameter int LEVEL = 0
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [2**LEVEL-1:0]                   node_wen,   // This level's slice of the enables
  input  logic [kd_tree_pkg::storage_width-1:0] node_wdata,
  input  logic                                  node_clear,
  input  logic                                  v_in,
  input  logic [kd_tree_pkg::patch_width-1:0]   patch_in,
  input  logic [((LEVEL == 0) ? 1 : LEVEL)-1:0] path_in,    // Level 0 gets a single zero bit
  output logic                                  v_out,
  output logic [kd_tree_pkg::patch_width-1:0]   patch_out,
  output logic [LEVEL:0]                        path_out
);

  localparam int num_level_nodes = 2**LEVEL;

  logic [num_level_nodes-1:0] go_right; // Decision of every node at this level
  logic                       decision; // Decision of the node on this query's path

  // Every node compares the same patch, the path picks the one that counts
  for (genvar n = 0; n < num_level_nodes; n++) begin : g_node
    internal_node u_node (
      .clk      (clk),
      .rst_n    (rst_n),
      .wen      (node_wen[n]),
      .clear    (node_clear),
      .wdata    (node_wdata),
      .patch_in (patch_in),
      .go_right (go_right[n])
    );
  end

  assign decision = go_right[path_in]; // Path so far is the local node number at this level

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      v_out <= 1'b0;
    end else begin
      v_out <= v_in;
    end
  end

  // New decision becomes the least significant bit, so the root ends up on top
  if (LEVEL == 0) begin : g_path_root
    always_ff @(posedge clk) path_out <= decision;
  end else begin : g_path_ext
    always_ff @(posedge clk) path_out <= {path_in, decision};
  end

  // Nothing follows the last level, so the patch stops here
  if (LEVEL == DEPTH - 1) begin : g_patch_last
    assign patch_out = '0;
  end else begin : g_patch_reg
    always_ff @(posedge clk) patch_out <= patch_in;
  end

endmodule

/* design/kd_tree_ctrl.sv */
`timescale 1ns/10ps

module kd_tree_ctrl #(
  parameter int DEPTH = 3
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    cmd_valid,
  input  kd_tree_pkg::kd_op_e                     cmd_op,
  input  logic [DEPTH-1:0]                        cmd_addr,
  input  logic [kd_tree_pkg::storage_width-1:0]   cmd_wdata,
  input  logic [kd_tree_pkg::patch_width-1:0]     cmd_patch,
  output logic [2**DEPTH-2:0]                     node_wen,   // One bit per node, heap order
  output logic [kd_tree_pkg::storage_width-1:0]   node_wdata,
  output logic                                    node_clear,
  output logic                                    q_valid,
  output logic [kd_tree_pkg::patch_width-1:0]     q_patch,
  output logic                                    tree_ready,
  output logic                                    query_drop
);

  localparam int num_nodes = 2**DEPTH - 1;

  kd_tree_pkg::kd_state_e state;
  kd_tree_pkg::kd_state_e state_next;

  logic [num_nodes-1:0] loaded;      // Set bit means that node holds host data
  logic [num_nodes-1:0] loaded_next;
  logic [num_nodes-1:0] wen_dec;     // Address decode of the incoming write

  logic is_write;
  logic is_query;
  logic is_clear;

  // Command decode, a strobe with op_nop does nothing
  assign is_write = cmd_valid && (cmd_op == kd_tree_pkg::op_write_node);
  assign is_query = cmd_valid && (cmd_op == kd_tree_pkg::op_query);
  assign is_clear = cmd_valid && (cmd_op == kd_tree_pkg::op_clear);

  // One-hot decode of the node address
  // The top address 2**DEPTH-1 matches no node, so such a write falls away here
  always_comb begin
    wen_dec = '0;
    for (int i = 0; i < num_nodes; i++) begin
      if (is_write && (int'(cmd_addr) == i)) wen_dec[i] = 1'b1;
    end
  end

  // Command register stage, everything to the tree leaves one cycle after the strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      node_wen   <= '0;
      node_clear <= 1'b0;
      q_valid    <= 1'b0;
      query_drop <= 1'b0;
    end else begin
      node_wen   <= wen_dec;
      node_clear <= is_clear;
      q_valid    <= is_query && (state == kd_tree_pkg::st_ready);  // Admitted query
      query_drop <= is_query && (state != kd_tree_pkg::st_ready);  // Flag and forget it
    end
  end

  // Payload copies that only matter when their strobe is high
  always_ff @(posedge clk) begin
    node_wdata <= cmd_wdata;
    q_patch    <= cmd_patch;
  end

  // The bitmap follows the registered strobes, so it moves on the same edge as the node
  assign loaded_next = node_clear ? '0 : (loaded | node_wen);

  always_comb begin
    if (&loaded_next) begin
      state_next = kd_tree_pkg::st_ready;
    end else if (|loaded_next) begin
      state_next = kd_tree_pkg::st_loading;
    end else begin
      state_next = kd_tree_pkg::st_empty;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      loaded <= '0;
      state  <= kd_tree_pkg::st_empty;
    end else begin
      loaded <= loaded_next; // Rewriting a node keeps its bit set, it never counts twice
      state  <= state_next;
    end
  end

  assign tree_ready = (state == kd_tree_pkg::st_ready);

endmodule

/* design/kd_tree_top.sv */
`timescale 1ns/10ps

module kd_tree_top #(
  parameter int DEPTH = 3
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  cmd_valid,
  input  kd_tree_pkg::kd_op_e                   cmd_op,
  input  logic [DEPTH-1:0]                      cmd_addr,
  input  logic [kd_tree_pkg::storage_width-1:0] cmd_wdata,
  input  logic [kd_tree_pkg::patch_width-1:0]   cmd_patch,
  output logic                                  leaf_valid,
  output logic [DEPTH-1:0]                      leaf_id,
  output logic                                  query_drop,
  output logic                                  tree_ready
);

  logic [2**DEPTH-2:0]                   node_wen;
  logic [kd_tree_pkg::storage_width-1:0] node_wdata;
  logic                                  node_clear;
  logic                                  q_valid;
  logic [kd_tree_pkg::patch_width-1:0]   q_patch;
  logic                                  q_path;   // Empty path into the root level

  assign q_path = 1'b0; // The root is node 0 of level 0

  kd_tree_ctrl #(
    .DEPTH (DEPTH)
  ) u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd_op     (cmd_op),
    .cmd_addr   (cmd_addr),
    .cmd_wdata  (cmd_wdata),
    .cmd_patch  (cmd_patch),
    .node_wen   (node_wen),
    .node_wdata (node_wdata),
    .node_clear (node_clear),
    .q_valid    (q_valid),
    .q_patch    (q_patch),
    .tree_ready (tree_ready),
    .query_drop (query_drop)
  );

  // Level l owns heap addresses 2**l-1 up to 2**(l+1)-2
  for (genvar l = 0; l < DEPTH; l++) begin : g_level
    logic                                v_o;
    logic [kd_tree_pkg::patch_width-1:0] patch_o;
    logic [l:0]                          path_o;

    if (l == 0) begin : g_root
      kd_tree_level #(
        .DEPTH (DEPTH),
        .LEVEL (0)
      ) u_level (
        .clk        (clk),
        .rst_n      (rst_n),
        .node_wen   (node_wen[0]),
        .node_wdata (node_wdata),
        .node_clear (node_clear),
        .v_in       (q_valid),
        .patch_in   (q_patch),
        .path_in    (q_path),
        .v_out      (v_o),
        .patch_out  (patch_o),
        .path_out   (path_o)
      );
    end else begin : g_inner
      kd_tree_level #(
        .DEPTH (DEPTH),
        .LEVEL (l)
      ) u_level (
        .clk        (clk),
        .rst_n      (rst_n),
        .node_wen   (node_wen[2**(l+1)-2:2**l-1]),
        .node_wdata (node_wdata),
        .node_clear (node_clear),
        .v_in       (g_level[l-1].v_o),     // Previous stage feeds this one
        .patch_in   (g_level[l-1].patch_o),
        .path_in    (g_level[l-1].path_o),
        .v_out      (v_o),
        .patch_out  (patch_o),
        .path_out   (path_o)
      );
    end
  end

  assign leaf_valid = g_level[DEPTH-1].v_o;    // Leaf strobe from the deepest stage
  assign leaf_id    = g_level[DEPTH-1].path_o; // Full path, root decision in the MSB

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  // Free running clock, low for the first half period
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

/* testbench/tb_kd_tree.sv */
`timescale 1ns/10ps

module tb_kd_tree;

  localparam int depth          = 3;
  localparam int num_nodes      = 7;
  localparam int timeout_cycles = 600; // Roughly twice the length of the whole sequence

  logic                                  clk;
  logic                                  rst_n;
  logic                                  cmd_valid;
  kd_tree_pkg::kd_op_e                   cmd_op;
  logic [depth-1:0]                      cmd_addr;
  logic [kd_tree_pkg::storage_width-1:0] cmd_wdata;
  logic [kd_tree_pkg::patch_width-1:0]   cmd_patch;
  logic                                  leaf_valid;
  logic [depth-1:0]                      leaf_id;
  logic                                  query_drop;
  logic                                  tree_ready;

  // Reference tree in heap order with its load state
  logic        [2:0]        model_idx [num_nodes];
  logic signed [10:0]       model_med [num_nodes];
  logic [num_nodes-1:0]     model_loaded;
  logic                     model_ready;
  logic                     rdy_d1 = 1'b0;
  logic                     rdy_d2 = 1'b0;  // Ready as the DUT control sees it at this edge

  // Expected leaves in arrival order, each tagged with the cycle it was accepted
  logic [depth-1:0] exp_leaf [16];
  int               exp_tag  [16];
  logic [3:0]       wr_ptr = '0;
  logic [3:0]       rd_ptr = '0;
  logic             pending;
  logic [depth-1:0] head_leaf;
  int               head_tag;

  logic        accepted;
  logic        dropped;
  int          cycle_count  = 0;
  int          value_errors = 0;
  int          other_errors = 0;
  logic [31:0] lfsr         = 32'heacc1666;

  tb_clock_gen #(.PERIOD_NS(40)) u_clk (.clk(clk));

  kd_tree_top #(.DEPTH(depth)) DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd_op     (cmd_op),
    .cmd_addr   (cmd_addr),
    .cmd_wdata  (cmd_wdata),
    .cmd_patch  (cmd_patch),
    .leaf_valid (leaf_valid),
    .leaf_id    (leaf_id),
    .query_drop (query_drop),
    .tree_ready (tree_ready)
  );

  assign accepted  = cmd_valid && (cmd_op == kd_tree_pkg::op_query) && rdy_d2;
  assign dropped   = cmd_valid && (cmd_op == kd_tree_pkg::op_query) && !rdy_d2;
  assign pending   = (wr_ptr != rd_ptr);
  assign head_leaf = exp_leaf[rd_ptr];
  assign head_tag  = exp_tag[rd_ptr];

  // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]}; // One step per bit taken
      lfsr = lfsr_next(lfsr);
    end
    return val;
  endfunction

  function automatic logic [54:0] random_patch();
    logic [54:0] p;
    for (int d = 0; d < 5; d++) p[d*11 +: 11] = 11'(rand_bits(11));
    return p;
  endfunction

  // Walk root to leaf, left below the median, right otherwise
  function automatic logic [depth-1:0] walk_tree(input logic [54:0] patch);
    logic signed [10:0] coord [5];
    logic signed [10:0] value;
    logic [depth-1:0]   path;
    logic               right;
    int                 node;
    for (int d = 0; d < 5; d++) coord[d] = patch[d*11 +: 11];
    path = '0;
    node = 0;
    for (int lvl = 0; lvl < depth; lvl++) begin
      value = (model_idx[node] < 3'd5) ? coord[model_idx[node]] : 11'sd0; // 5 to 7 read zero
      right = (value >= model_med[node]);
      path  = {path[depth-2:0], right};     // Root decision ends up as the MSB
      node  = 2 * node + 1 + (right ? 1 : 0);
    end
    return path;
  endfunction

  // Force the coordinate a node splits on to equal its median
  function automatic logic [54:0] tie_at(input logic [54:0] patch, input int node);
    logic [54:0] p;
    p = patch;
    if (model_idx[node] < 3'd5) p[model_idx[node]*11 +: 11] = model_med[node];
    return p;
  endfunction

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
      cmd_valid = 1'b0;
      cmd_op    = kd_tree_pkg::op_nop;
    end
  endtask

  task automatic send_write(input int addr, input logic [2:0] idx, input logic signed [10:0] med);
    logic [7:0] junk;
    junk = 8'(rand_bits(8)); // Upper index bits carry noise the node must ignore
    @(posedge clk);
    #2;
    cmd_valid = 1'b1;
    cmd_op    = kd_tree_pkg::op_write_node;
    cmd_addr  = addr[2:0];
    cmd_wdata = {med, junk, idx};
    if (addr < num_nodes) begin
      model_idx[addr]    = idx;
      model_med[addr]    = med;
      model_loaded[addr] = 1'b1;
    end
    model_ready = &model_loaded;
  endtask

  task automatic write_random(input int addr);
    send_write(addr, 3'(rand_bits(3) % 5), 11'(rand_bits(11)));
  endtask

  task automatic send_query(input logic [54:0] patch);
    @(posedge clk);
    #2;
    cmd_valid = 1'b1;
    cmd_op    = kd_tree_pkg::op_query;
    cmd_patch = patch;
  endtask

  task automatic send_clear();
    @(posedge clk);
    #2;
    cmd_valid = 1'b1;
    cmd_op    = kd_tree_pkg::op_clear;
    for (int n = 0; n < num_nodes; n++) begin
      model_idx[n] = 3'd7; // Unloaded marker
      model_med[n] = '0;
    end
    model_loaded = '0;
    model_ready  = 1'b0;
  endtask

  // Back to back queries, some tied at the root or at the level 1 node on the path
  task automatic run_queries(input int n);
    logic [54:0]      patch;
    logic [depth-1:0] leaf;
    for (int i = 0; i < n; i++) begin
      patch = random_patch();
      if (i % 4 == 1) begin
        patch = tie_at(patch, 0);
      end else if (i % 4 == 3) begin
        leaf  = walk_tree(patch);
        patch = tie_at(patch, leaf[depth-1] ? 2 : 1);
      end
      send_query(patch);
    end
    idle(1);
  endtask

  task automatic wait_drain();
    while (pending) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic print_counts();
    $display("errors: %0d value, %0d other", value_errors, other_errors);
  endtask

  // Expected leaf queue and the control's view of ready, two cycles behind the model
  always @(posedge clk) begin
    if (!rst_n) begin
      rdy_d1 <= 1'b0;
      rdy_d2 <= 1'b0;
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      cycle_count <= cycle_count + 1;
      rdy_d1      <= model_ready;
      rdy_d2      <= rdy_d1;
      if (accepted) begin
        exp_leaf[wr_ptr] <= walk_tree(cmd_patch);
        exp_tag[wr_ptr]  <= cycle_count;
        wr_ptr           <= wr_ptr + 1'b1;
      end
      if (leaf_valid && pending) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  a_leaf_timing : assert property (@(posedge clk) disable iff (!rst_n)
    $past(accepted, 4) |-> leaf_valid)
    else begin
      value_errors++;
      $display("FAILED %0t leaf_valid expected 1 actual %0b", $time, $sampled(leaf_valid));
    end

  a_leaf_orphan : assert property (@(posedge clk) disable iff (!rst_n) leaf_valid |-> pending)
    else begin
      other_errors++;
      $display("ERROR %0t leaf_valid came out with no query in flight", $time);
    end

  a_leaf_latency : assert property (@(posedge clk) disable iff (!rst_n)
    (leaf_valid && pending) |-> (cycle_count - head_tag == 4))
    else begin
      value_errors++;
      $display("FAILED %0t leaf latency expected 4 actual %0d", $time,
               $sampled(cycle_count) - $sampled(head_tag));
    end

  a_leaf_id : assert property (@(posedge clk) disable iff (!rst_n)
    (leaf_valid && pending) |-> (leaf_id == head_leaf))
    else begin
      value_errors++;
      $display("FAILED %0t leaf_id expected %0d actual %0d", $time,
               $sampled(head_leaf), $sampled(leaf_id));
    end

  a_drop : assert property (@(posedge clk) disable iff (!rst_n) query_drop == $past(dropped))
    else begin
      value_errors++;
      $display("FAILED %0t query_drop expected %0b actual %0b", $time,
               $past(dropped), $sampled(query_drop));
    end

  a_ready : assert property (@(posedge clk) disable iff (!rst_n) tree_ready == rdy_d2)
    else begin
      value_errors++;
      $display("FAILED %0t tree_ready expected %0b actual %0b", $time,
               $sampled(rdy_d2), $sampled(tree_ready));
    end

  // Hard stop so a stuck pipeline cannot hang the run
  always @(posedge clk) begin
    if (cycle_count >= timeout_cycles) begin
      $display("ERROR timeout, the run did not finish within %0d cycles", timeout_cycles);
      print_counts();
      $display("test failed");
      $finish;
    end
  end

  initial begin
    rst_n        = 1'b0;
    cmd_valid    = 1'b0;
    cmd_op       = kd_tree_pkg::op_nop;
    cmd_addr     = '0;
    cmd_wdata    = '0;
    cmd_patch    = '0;
    model_loaded = '0;
    model_ready  = 1'b0;
    for (int n = 0; n < num_nodes; n++) begin
      model_idx[n] = 3'd7;
      model_med[n] = '0;
    end
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Query on an empty tree is dropped
    idle(2);
    send_query(random_patch());
    idle(3);

    // Six nodes, a query while loading, a repeated node and an address past the tree
    for (int a = 0; a < 6; a++) begin
      write_random(a);
      idle(1);
    end
    send_query(random_patch());
    write_random(2);
    write_random(7);
    idle(3);
    write_random(6); // Completes the set
    idle(3);

    run_queries(150);
    wait_drain();

    // New split for the root, index 6 on node 4 so it compares zero
    idle(5);
    send_write(0, 3'((model_idx[0] + 1) % 5), 11'(rand_bits(11)));
    send_write(4, 3'd6, 11'(rand_bits(11)));
    idle(3);
    run_queries(40);
    wait_drain();

    // Clear, queries dropped while reloading, then results match again
    send_clear();
    idle(3);
    send_query(random_patch());
    for (int a = 0; a < 4; a++) write_random(a);
    send_query(random_patch());
    for (int a = 4; a < num_nodes; a++) write_random(a);
    idle(3);
    run_queries(20);
    wait_drain();
    idle(4);

    if (pending) begin
      other_errors++;
      $display("ERROR accepted queries never produced a leaf");
    end
    print_counts();
    if (value_errors + other_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* tb.f */
design/kd_tree_pkg.sv
design/internal_node.sv
design/kd_tree_level.sv
design/kd_tree_ctrl.sv
design/kd_tree_top.sv
testbench/tb_clock_gen.sv
testbench/tb_kd_tree.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_kd_tree -f tb.f -o sim_kd_tree
./obj_dir/sim_kd_tree | tee sim.log

if grep -qx "test passed" sim.log; then
  echo "simulation PASS"
else
  echo "simulation FAIL"
  exit 1
fi
